//--- hdl/DataRam.sv
// Word wide data RAM with per-byte synchronous write and combinational read
`timescale 1ns/10ps

module DataRam #(
    parameter int RamAddrW = 8
) (
    input  logic                clk,
    input  logic [RamAddrW-1:0] ramAddr,
    input  logic                ramWe,
    input  logic [3:0]          ramBe,
    input  logic [31:0]         ramWData,
    output logic [31:0]         ramRData
);

    localparam int Depth = 2 ** RamAddrW;

    logic [31:0] mem [Depth];

    always_ff @(posedge clk) begin
        if (ramWe) begin
            for (int i = 0; i < 4; i++) begin
                if (ramBe[i]) begin
                    mem[ramAddr][8*i +: 8] <= ramWData[8*i +: 8]; // Only enabled lanes change
                end
            end
        end
    end

    assign ramRData = mem[ramAddr];

endmodule

//--- hdl/ExMemTop.sv
// Execute and memory half of the pipeline with its data RAM
`timescale 1ns/10ps

module ExMemTop import PipePkg::*; #(
    parameter int RamAddrW = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              advance,
    input  logic              flush,
    input  logic              exeValid,
    input  logic [AluOpW-1:0] aluOp,
    input  logic [31:0]       opA,
    input  logic [31:0]       opB,
    input  logic [31:0]       storeData,
    input  logic [4:0]        dst,
    input  logic              regWr,
    input  logic [2:0]        loadType,
    input  logic [1:0]        storeType,
    input  logic [31:0]       pc,
    output logic              wbValid,
    output logic              wbRegWr,
    output logic [4:0]        wbDst,
    output logic [31:0]       wbData,
    output logic [31:0]       wbPc,
    output logic [1:0]        wbExc,
    output logic [31:0]       wbBadAddr
);

    logic [31:0]         aluOut;
    logic [1:0]          exeExc;
    logic                memValid;
    logic [31:0]         memAluOut;
    logic [31:0]         memStoreData;
    logic [4:0]          memDst;
    logic                memRegWr;
    logic [2:0]          memLoadType;
    logic [1:0]          memStoreType;
    logic [31:0]         memPc;
    logic [1:0]          memExc;
    logic [RamAddrW-1:0] ramAddr;
    logic                ramWe;
    logic [3:0]          ramBe;
    logic [31:0]         ramWData;
    logic [31:0]         ramRData;
    logic [31:0]         loadData;
    logic [1:0]          accExc;

    ExecuteUnit i_exe (
        .aluOp(aluOp), .opA(opA), .opB(opB), .aluOut(aluOut), .exeExc(exeExc)
    );

    ExeMemReg i_exeMem (
        .clk(clk), .rst(rst), .flush(flush), .advance(advance), .exeValid(exeValid),
        .aluOut(aluOut), .exeExc(exeExc), .storeData(storeData), .dst(dst),
        .regWr(regWr), .loadType(loadType), .storeType(storeType), .pc(pc),
        .memValid(memValid), .memAluOut(memAluOut), .memStoreData(memStoreData),
        .memDst(memDst), .memRegWr(memRegWr), .memLoadType(memLoadType),
        .memStoreType(memStoreType), .memPc(memPc), .memExc(memExc)
    );

    MemAccess #(.RamAddrW(RamAddrW)) i_mem (
        .advance(advance), .memValid(memValid), .memAluOut(memAluOut),
        .memStoreData(memStoreData), .memLoadType(memLoadType),
        .memStoreType(memStoreType), .memExc(memExc), .ramRData(ramRData),
        .ramAddr(ramAddr), .ramWe(ramWe), .ramBe(ramBe), .ramWData(ramWData),
        .loadData(loadData), .accExc(accExc)
    );

    DataRam #(.RamAddrW(RamAddrW)) i_ram (
        .clk(clk), .ramAddr(ramAddr), .ramWe(ramWe), .ramBe(ramBe),
        .ramWData(ramWData), .ramRData(ramRData)
    );

    MemWbReg i_memWb (
        .clk(clk), .rst(rst), .advance(advance), .memValid(memValid),
        .memRegWr(memRegWr), .memDst(memDst), .memPc(memPc),
        .memLoadType(memLoadType), .memAluOut(memAluOut), .loadData(loadData),
        .accExc(accExc), .wbValid(wbValid), .wbRegWr(wbRegWr), .wbDst(wbDst),
        .wbData(wbData), .wbPc(wbPc), .wbExc(wbExc), .wbBadAddr(wbBadAddr)
    );

endmodule

//--- hdl/ExeMemReg.sv
// Execute to memory pipeline register with flush, hold and a valid bit
`timescale 1ns/10ps

module ExeMemReg import PipePkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        advance,
    input  logic        exeValid,
    input  logic [31:0] aluOut,
    input  logic [1:0]  exeExc,
    input  logic [31:0] storeData,
    input  logic [4:0]  dst,
    input  logic        regWr,
    input  logic [2:0]  loadType,
    input  logic [1:0]  storeType,
    input  logic [31:0] pc,
    output logic        memValid,
    output logic [31:0] memAluOut,
    output logic [31:0] memStoreData,
    output logic [4:0]  memDst,
    output logic        memRegWr,
    output logic [2:0]  memLoadType,
    output logic [1:0]  memStoreType,
    output logic [31:0] memPc,
    output logic [1:0]  memExc
);

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            memValid     <= 1'b0;
            memAluOut    <= 32'b0;
            memStoreData <= 32'b0;
            memDst       <= 5'b0;
            memRegWr     <= 1'b0;
            memLoadType  <= LoadNone;
            memStoreType <= StoreNone;
            memPc        <= 32'b0;
            memExc       <= ExcNone;
        end else if (flush) begin // Turns the stage into a bubble, wins over advance
            memValid     <= 1'b0;
            memAluOut    <= 32'b0;
            memStoreData <= 32'b0;
            memDst       <= 5'b0;
            memRegWr     <= 1'b0;
            memLoadType  <= LoadNone;
            memStoreType <= StoreNone;
            memPc        <= 32'b0;
            memExc       <= ExcNone;
        end else if (advance) begin
            memValid     <= exeValid;
            memAluOut    <= aluOut;
            memStoreData <= storeData;
            memDst       <= dst;
            memRegWr     <= regWr;
            memLoadType  <= loadType;
            memStoreType <= storeType;
            memPc        <= pc;
            memExc       <= exeExc;
        end
    end

    // An instruction is a load, a store, or neither
    aLoadStoreExclusive: assert property (@(posedge clk) disable iff (!rst)
        memValid |-> !(memLoadType != LoadNone && memStoreType != StoreNone))
        else $error("ExeMemReg holds a load and a store in one instruction");

endmodule

//--- hdl/ExecuteUnit.sv
// Execute stage ALU with signed overflow detection
`timescale 1ns/10ps

module ExecuteUnit import PipePkg::*; (
    input  logic [AluOpW-1:0] aluOp,
    input  logic [31:0]       opA,
    input  logic [31:0]       opB,
    output logic [31:0]       aluOut,
    output logic [1:0]        exeExc
);

    logic [31:0] sum;
    logic [31:0] diff;
    logic [4:0]  shAmt;
    logic        addOvf;
    logic        subOvf;

    assign sum   = opA + opB;
    assign diff  = opA - opB;
    assign shAmt = opA[4:0]; // Shift amount comes from the low bits of A

    // Operands of equal sign whose sum flips sign
    assign addOvf = (opA[31] == opB[31]) && (sum[31] != opA[31]);
    assign subOvf = (opA[31] != opB[31]) && (diff[31] != opA[31]);

    always_comb begin
        aluOut = 32'b0;
        exeExc = ExcNone;
        case (aluOp)
            AluAdd: begin
                aluOut = sum;
                if (addOvf) begin
                    exeExc = ExcOverflow;
                end
            end
            AluAddu: aluOut = sum;
            AluSub: begin
                aluOut = diff;
                if (subOvf) begin
                    exeExc = ExcOverflow;
                end
            end
            AluSubu: aluOut = diff;
            AluAnd:  aluOut = opA & opB;
            AluOr:   aluOut = opA | opB;
            AluXor:  aluOut = opA ^ opB;
            AluNor:  aluOut = ~(opA | opB);
            AluSlt:  aluOut = {31'b0, $signed(opA) < $signed(opB)};
            AluSltu: aluOut = {31'b0, opA < opB};
            AluSll:  aluOut = opB << shAmt;
            AluSrl:  aluOut = opB >> shAmt;
            AluSra:  aluOut = $unsigned($signed(opB) >>> shAmt);
            AluLui:  aluOut = {opB[15:0], 16'b0};
            default: aluOut = 32'b0;
        endcase
    end

endmodule

//--- hdl/MemAccess.sv
// Memory stage with store lane placement, address checks and load extension
`timescale 1ns/10ps

module MemAccess import PipePkg::*; #(
    parameter int RamAddrW = 8
) (
    input  logic                advance,
    input  logic                memValid,
    input  logic [31:0]         memAluOut,
    input  logic [31:0]         memStoreData,
    input  logic [2:0]          memLoadType,
    input  logic [1:0]          memStoreType,
    input  logic [1:0]          memExc,
    input  logic [31:0]         ramRData,
    output logic [RamAddrW-1:0] ramAddr,
    output logic                ramWe,
    output logic [3:0]          ramBe,
    output logic [31:0]         ramWData,
    output logic [31:0]         loadData,
    output logic [1:0]          accExc
);

    MemWord     rdWord;
    logic [1:0] lane;
    logic [7:0] rdByte;
    logic [15:0] rdHalf;
    logic       loadMis;
    logic       storeMis;

    assign ramAddr = memAluOut[RamAddrW+1:2]; // Word address
    assign lane    = memAluOut[1:0];

    assign loadMis = ((memLoadType == LoadH || memLoadType == LoadHu) && lane[0])
                     || (memLoadType == LoadW && lane != 2'b00);
    assign storeMis = (memStoreType == StoreH && lane[0])
                      || (memStoreType == StoreW && lane != 2'b00);

    ////////////////////
    // Store path
    ////////////////////
    always_comb begin
        ramBe    = 4'b0000;
        ramWData = memStoreData;
        case (memStoreType)
            StoreB: begin
                ramBe    = 4'b0001 << lane;
                ramWData = {4{memStoreData[7:0]}};
            end
            StoreH: begin
                ramBe    = lane[1] ? 4'b1100 : 4'b0011;
                ramWData = {2{memStoreData[15:0]}};
            end
            StoreW: ramBe = 4'b1111;
            default: ramBe = 4'b0000;
        endcase
    end

    always_comb begin
        accExc = ExcNone;
        if (memExc != ExcNone) begin
            accExc = memExc; // Execute exception wins
        end else if (memValid && loadMis) begin
            accExc = ExcAdEL;
        end else if (memValid && storeMis) begin
            accExc = ExcAdES;
        end
        ramWe = advance && memValid && memStoreType != StoreNone && accExc == ExcNone;
    end

    ////////////////////
    // Load path
    ////////////////////
    assign rdWord = ramRData;
    assign rdByte = rdWord.bytes[lane];
    assign rdHalf = rdWord.halves[lane[1]];

    always_comb begin
        case (memLoadType)
            LoadB:   loadData = {{24{rdByte[7]}}, rdByte};
            LoadBu:  loadData = {24'b0, rdByte};
            LoadH:   loadData = {{16{rdHalf[15]}}, rdHalf};
            LoadHu:  loadData = {16'b0, rdHalf};
            LoadW:   loadData = rdWord;
            default: loadData = 32'b0;
        endcase
    end

endmodule

//--- hdl/MemWbReg.sv
// Memory to writeback pipeline register with writeback data selection
`timescale 1ns/10ps

module MemWbReg import PipePkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        advance,
    input  logic        memValid,
    input  logic        memRegWr,
    input  logic [4:0]  memDst,
    input  logic [31:0] memPc,
    input  logic [2:0]  memLoadType,
    input  logic [31:0] memAluOut,
    input  logic [31:0] loadData,
    input  logic [1:0]  accExc,
    output logic        wbValid,
    output logic        wbRegWr,
    output logic [4:0]  wbDst,
    output logic [31:0] wbData,
    output logic [31:0] wbPc,
    output logic [1:0]  wbExc,
    output logic [31:0] wbBadAddr
);

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            wbValid   <= 1'b0;
            wbRegWr   <= 1'b0;
            wbDst     <= 5'b0;
            wbData    <= 32'b0;
            wbPc      <= 32'b0;
            wbExc     <= ExcNone;
            wbBadAddr <= 32'b0;
        end else if (advance) begin
            wbValid   <= memValid;
            wbRegWr   <= memValid && memRegWr && accExc == ExcNone; // Exceptions kill the write
            wbDst     <= memDst;
            wbData    <= (memLoadType != LoadNone) ? loadData : memAluOut;
            wbPc      <= memPc;
            wbExc     <= accExc;
            wbBadAddr <= memAluOut;
        end
    end

endmodule

//--- hdl/PipePkg.sv
// Shared codes, widths and the memory word layout of the execute and memory stages
package PipePkg;

    ////////////////////
    // ALU operations
    ////////////////////
    localparam int AluOpW = 4;

    localparam logic [AluOpW-1:0] AluAdd  = 4'd0;
    localparam logic [AluOpW-1:0] AluAddu = 4'd1;
    localparam logic [AluOpW-1:0] AluSub  = 4'd2;
    localparam logic [AluOpW-1:0] AluSubu = 4'd3;
    localparam logic [AluOpW-1:0] AluAnd  = 4'd4;
    localparam logic [AluOpW-1:0] AluOr   = 4'd5;
    localparam logic [AluOpW-1:0] AluXor  = 4'd6;
    localparam logic [AluOpW-1:0] AluNor  = 4'd7;
    localparam logic [AluOpW-1:0] AluSlt  = 4'd8;
    localparam logic [AluOpW-1:0] AluSltu = 4'd9;
    localparam logic [AluOpW-1:0] AluSll  = 4'd10;
    localparam logic [AluOpW-1:0] AluSrl  = 4'd11;
    localparam logic [AluOpW-1:0] AluSra  = 4'd12;
    localparam logic [AluOpW-1:0] AluLui  = 4'd13;

    ////////////////////
    // Memory operations
    ////////////////////
    localparam logic [2:0] LoadNone = 3'd0;
    localparam logic [2:0] LoadB    = 3'd1; // Signed byte
    localparam logic [2:0] LoadBu   = 3'd2;
    localparam logic [2:0] LoadH    = 3'd3; // Signed halfword
    localparam logic [2:0] LoadHu   = 3'd4;
    localparam logic [2:0] LoadW    = 3'd5;

    localparam logic [1:0] StoreNone = 2'd0;
    localparam logic [1:0] StoreB    = 2'd1;
    localparam logic [1:0] StoreH    = 2'd2;
    localparam logic [1:0] StoreW    = 2'd3;

    localparam logic [1:0] ExcNone     = 2'd0;
    localparam logic [1:0] ExcOverflow = 2'd1;
    localparam logic [1:0] ExcAdEL     = 2'd2; // Address error on load
    localparam logic [1:0] ExcAdES     = 2'd3; // Address error on store

    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } MemWord;

endpackage

//--- list.f
hdl/PipePkg.sv
hdl/ExecuteUnit.sv
hdl/ExeMemReg.sv
hdl/MemAccess.sv
hdl/DataRam.sv
hdl/MemWbReg.sv
hdl/ExMemTop.sv
verification/ExMemTb.sv

//--- runSim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass message
verilator --binary --timing --assert -f list.f --top-module ExMemTb -o simv \
    && ./obj_dir/simv | grep -q "ALL TESTS PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- verification/ExMemTb.sv
// Testbench for the execute and memory pipeline half with a model of its memory
`timescale 1ns/10ps

module ExMemTb import PipePkg::*; ();

    localparam int RamAddrW = 8;
    localparam int Slots    = 256 + 150 + 4 + 80 + 5 + 50 + 12 + 3;
    localparam int MaxCycle = 2 * Slots + 50;

    typedef struct packed {
        logic [3:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sd;
        logic [4:0]  dst;
        logic        rw;
        logic [2:0]  lt;
        logic [1:0]  st;
        logic [31:0] pc;
    } Instr;

    typedef struct packed {
        logic [31:0] data;
        logic [4:0]  dst;
        logic        rw;
        logic [1:0]  exc;
        logic [31:0] pc;
        logic [31:0] bad;
    } Expect;

    logic clk, rst, advance, flush, exeValid, regWr;
    logic [3:0] aluOp;
    logic [31:0] opA, opB, storeData, pc;
    logic [4:0] dst;
    logic [2:0] loadType;
    logic [1:0] storeType;
    logic wbValid, wbRegWr;
    logic [4:0] wbDst;
    logic [31:0] wbData, wbPc, wbBadAddr;
    logic [1:0] wbExc;

    logic [31:0] modelMem [2**RamAddrW];
    Instr  pending [$];
    Expect exp;
    logic  prevAdv, retExpected;
    int    cycles, retired, errCount;
    logic [29:0] w;
    logic [2:0] lt;
    logic [1:0] st, ln;

    ExMemTop #(.RamAddrW(RamAddrW)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic Expect computeModel(Instr x);
        Expect e;
        logic [32:0] wide;
        logic [31:0] res;
        logic mis;
        MemWord mw;
        e.exc = ExcNone;
        case (x.op)
            AluAdd, AluAddu: res = x.a + x.b;
            AluSub, AluSubu: res = x.a - x.b;
            AluAnd:  res = x.a & x.b;
            AluOr:   res = x.a | x.b;
            AluXor:  res = x.a ^ x.b;
            AluNor:  res = ~(x.a | x.b);
            AluSlt:  res = ($signed(x.a) < $signed(x.b)) ? 32'd1 : 32'd0;
            AluSltu: res = (x.a < x.b) ? 32'd1 : 32'd0;
            AluSll:  res = x.b << x.a[4:0];
            AluSrl:  res = x.b >> x.a[4:0];
            AluSra:  res = $signed(x.b) >>> x.a[4:0];
            default: res = x.b << 16;
        endcase
        // A 33 bit signed result whose top two bits differ has overflowed
        wide = (x.op == AluSub) ? {x.a[31], x.a} - {x.b[31], x.b}
                                : {x.a[31], x.a} + {x.b[31], x.b};
        if ((x.op == AluAdd || x.op == AluSub) && wide[32] != wide[31]) e.exc = ExcOverflow;
        mis = ((x.lt == LoadH || x.lt == LoadHu || x.st == StoreH) && res[0])
              || ((x.lt == LoadW || x.st == StoreW) && res[1:0] != 2'b00);
        if (e.exc == ExcNone && mis) e.exc = (x.lt != LoadNone) ? ExcAdEL : ExcAdES;
        mw = modelMem[res[RamAddrW+1:2]];
        if (e.exc == ExcNone && x.st != StoreNone) begin
            case (x.st)
                StoreB:  mw.bytes[res[1:0]] = x.sd[7:0];
                StoreH:  mw.halves[res[1]] = x.sd[15:0];
                default: mw = x.sd;
            endcase
            modelMem[res[RamAddrW+1:2]] = mw;
        end
        case (x.lt)
            LoadB:   e.data = {{24{mw.bytes[res[1:0]][7]}}, mw.bytes[res[1:0]]};
            LoadBu:  e.data = {24'b0, mw.bytes[res[1:0]]};
            LoadH:   e.data = {{16{mw.halves[res[1]][15]}}, mw.halves[res[1]]};
            LoadHu:  e.data = {16'b0, mw.halves[res[1]]};
            LoadW:   e.data = mw;
            default: e.data = res;
        endcase
        e.dst = x.dst;
        e.rw  = x.rw && e.exc == ExcNone;
        e.pc  = x.pc;
        e.bad = res;
        return e;
    endfunction

    ////////////////////
    // Pipeline tracking
    ////////////////////
    always @(posedge clk, negedge rst) begin
        if (!rst) begin
            prevAdv     <= 1'b0;
            retExpected <= 1'b0;
        end else begin
            cycles++;
            prevAdv     <= advance;
            retExpected <= 1'b0;
            if (flush) begin
                pending.delete(); // Stall plus flush drops the memory stage
            end else if (advance) begin
                if (pending.size() > 0) begin
                    exp         <= computeModel(pending.pop_front());
                    retExpected <= 1'b1;
                    retired++;
                end
                if (exeValid) begin
                    pending.push_back({aluOp, opA, opB, storeData, dst, regWr,
                                       loadType, storeType, pc});
                end
            end
            if (cycles > MaxCycle) begin
                $display("Timeout after %0d cycles with the run still going", cycles);
                $display("SOME TESTS FAILED");
                $finish;
            end
        end
    end

    aRetireCount: assert property (@(posedge clk) disable iff (!rst)
        (prevAdv && wbValid) == retExpected)
        else begin
            errCount++;
            $display("At %0t a retirement was missing or had no instruction behind it", $time);
        end

    aRetireValue: assert property (@(posedge clk) disable iff (!rst)
        (prevAdv && wbValid && retExpected) |-> (wbData == exp.data && wbDst == exp.dst
            && wbRegWr == exp.rw && wbExc == exp.exc && wbPc == exp.pc
            && wbBadAddr == exp.bad))
        else begin
            errCount++;
            $display("Fail %0t: pc %h gave data %h exc %0d, expected %h exc %0d",
                     $time, wbPc, wbData, wbExc, exp.data, exp.exc);
        end

    task automatic issueInstr(input logic [3:0] op, input logic [31:0] a, input logic [31:0] b,
                              input logic [31:0] sd, input logic rw, input logic [2:0] ltIn,
                              input logic [1:0] stIn);
        @(negedge clk);
        {advance, flush, exeValid} = 3'b101;
        {aluOp, opA, opB, storeData, regWr, loadType, storeType} = {op, a, b, sd, rw, ltIn, stIn};
        dst = 5'($urandom);
        pc  = pc + 4;
    endtask

    task automatic holdCycles(input int n, input logic doFlush);
        repeat (n) begin
            @(negedge clk);
            {advance, flush, exeValid} = {1'b0, doFlush, 1'b0};
        end
    endtask

    initial begin
        void'($urandom(21915));
        {advance, flush, exeValid, regWr, aluOp, opA, opB} = '0;
        {storeData, dst, loadType, storeType, pc} = '0;
        {cycles, retired, errCount} = '0;
        rst = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk) rst = 1'b1;
        for (int i = 0; i < 256; i++) begin // Every word gets a known value first
            issueInstr(AluAddu, i * 4, 0, i * 32'h9E3779B1 ^ 32'h5A5A0000, 0, LoadNone, StoreW);
        end
        repeat (150) begin
            issueInstr(4'($urandom % 14), $urandom, $urandom, 0, 1'($urandom),
                       LoadNone, StoreNone);
        end
        issueInstr(AluAdd, 32'h7FFFFFFF, 1, 0, 1, LoadNone, StoreNone);
        issueInstr(AluAddu, 32'h7FFFFFFF, 1, 0, 1, LoadNone, StoreNone);
        issueInstr(AluSub, 32'h80000000, 1, 0, 1, LoadNone, StoreNone);
        issueInstr(AluSubu, 32'h80000000, 1, 0, 1, LoadNone, StoreNone);
        repeat (40) begin
            w  = 30'($urandom);
            st = 2'(1 + $urandom % 3);
            ln = (st == StoreB) ? 2'($urandom) : (st == StoreH) ? {1'($urandom), 1'b0} : 2'b00;
            issueInstr(AluAddu, {w, ln}, 0, $urandom, 0, LoadNone, st);
            lt = 3'(1 + $urandom % 5);
            ln = (lt <= LoadBu) ? 2'($urandom) : (lt <= LoadHu) ? {1'($urandom), 1'b0} : 2'b00;
            issueInstr(AluAddu, {w, ln}, 0, 0, 1, lt, StoreNone);
        end
        w = 30'($urandom);
        issueInstr(AluAddu, {w, 2'd1}, 0, 0, 1, LoadH, StoreNone);
        issueInstr(AluAddu, {w, 2'd2}, 0, 0, 1, LoadW, StoreNone);
        issueInstr(AluAddu, {w, 2'd3}, 0, 32'hDEADBEEF, 0, LoadNone, StoreH);
        issueInstr(AluAddu, {w, 2'd1}, 0, 32'hDEADBEEF, 0, LoadNone, StoreW);
        issueInstr(AluAddu, {w, 2'd0}, 0, 0, 1, LoadW, StoreNone);
        repeat (10) begin // Stores held in the memory stage across a stall
            w = 30'($urandom);
            issueInstr(AluAddu, {w, 2'd0}, 0, $urandom, 0, LoadNone, StoreW);
            holdCycles(1 + $urandom % 3, 1'b0);
            issueInstr(AluAddu, {w, 2'd0}, 0, 0, 1, LoadW, StoreNone);
        end
        repeat (4) begin
            w = 30'($urandom);
            issueInstr(AluAddu, {w, 2'd0}, 0, $urandom, 0, LoadNone, StoreW);
            holdCycles(1, 1'b1);
            issueInstr(AluAddu, {w, 2'd0}, 0, 0, 1, LoadW, StoreNone);
        end
        repeat (3) begin
            @(negedge clk);
            {advance, flush, exeValid} = 3'b100;
        end
        @(negedge clk);
        if (pending.size() != 0) begin
            errCount++;
            $display("%0d instructions never retired", pending.size());
        end
        $display("Retired %0d instructions in %0d cycles with %0d errors",
                 retired, cycles, errCount);
        if (errCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
